// File: hw/video_consts.svh
/* raster timing, palette depth and colour field widths for the palette back end
   include wherever a module or the package needs them */
`ifndef VIDEO_CONSTS_SVH
`define VIDEO_CONSTS_SVH

// horizontal, in clocks (short line for quick sims)
`define VID_H_TOTAL      32
`define VID_H_PIX_BEG    4   // left border is cols 0..3
`define VID_H_PIX_END    20
`define VID_H_BLANK_BEG  24  // blank runs to end of line
`define VID_H_SYNC_BEG   26
`define VID_H_SYNC_END   29

// vertical, in lines
`define VID_V_TOTAL      24
`define VID_V_PIX_BEG    3
`define VID_V_PIX_END    15
`define VID_V_BLANK_BEG  18
`define VID_V_SYNC_BEG   19
`define VID_V_SYNC_END   21

// palette
`define VID_PAL_DEPTH    512
`define VID_UP_BASE      256  // ulaplus table starts here
`define VID_ZX_W         4    // bright + grb
`define VID_UP_COL_W     3    // ulaplus ink/paper colour
`define VID_RG_W         3    // green, red fields of an entry
`define VID_BLU_W        2

`endif

// File: hw/video_pkg.sv
/* shared types of the palette back end: the palette index in its two
   decodings and the GGGRRRBB palette entry */
`include "video_consts.svh"

package video_pkg;

	// plain zx colour, top bits always zero
	typedef struct packed
	{
		logic [8-`VID_ZX_W:0] pad;   // zero
		logic [`VID_ZX_W-1:0] color; // bright, g, r, b
	} pal_zx_t;

	// ulaplus colour, lands in upper half of the ram
	typedef struct packed
	{
		logic [2:0]               tag;    // always 3'b100
		logic [1:0]               palsel; // one of four 16-entry groups
		logic                     paper;  // 1 = paper, 0 = ink
		logic [`VID_UP_COL_W-1:0] color;
	} pal_up_t;

	// one 9-bit ram address, decoded either way
	typedef union packed
	{
		pal_zx_t zx;
		pal_up_t up;
	} pal_index_t;

	// palette word as stored
	typedef struct packed
	{
		logic [`VID_RG_W-1:0]  green;
		logic [`VID_RG_W-1:0]  red;
		logic [`VID_BLU_W-1:0] blue;
	} pal_entry_t;

endpackage

// File: hw/video_raster.sv
/* raster timing generator: pixel and line counters, blank and sync levels,
   and the 9-bit palette index for the current pixel or border clock */
`timescale 1ns/1ps
`include "video_consts.svh"

module video_raster
(
	input  logic                 clk,
	input  logic                 rst_n,

	input  logic [3:0]           pixels,
	input  logic [3:0]           border,

	input  logic [1:0]           up_palsel,
	input  logic [2:0]           up_paper,
	input  logic [2:0]           up_ink,
	input  logic                 up_pixel,
	input  logic                 up_ena,

	output video_pkg::pal_index_t pal_index,
	output logic [3:0]           atm_index,  // zx colour, addresses atm writes

	output logic                 hblank,
	output logic                 vblank,
	output logic                 hsync,
	output logic                 vsync,
	output logic                 hsync_start // one clock at sync column
);
	localparam int HW = $clog2(`VID_H_TOTAL);
	localparam int VW = $clog2(`VID_V_TOTAL);

	logic [HW-1:0] hcount; // current column
	logic [VW-1:0] vcount; // current line
	logic [HW-1:0] h_next;
	logic [VW-1:0] v_next;
	logic          h_wrap;
	logic          v_wrap;
	logic          hpix;   // column inside picture
	logic          vpix;   // line inside picture
	logic          pix_area;
	logic [3:0]    zx_color;

	assign h_wrap = (hcount == HW'(`VID_H_TOTAL - 1));
	assign v_wrap = (vcount == VW'(`VID_V_TOTAL - 1));
	assign h_next = h_wrap ? '0 : hcount + 1'b1;

	always_comb
	begin
		v_next = vcount;
		if (h_wrap)
			v_next = v_wrap ? '0 : vcount + 1'b1; // step line at end of row
	end

	// levels are compared on the next count so they line up with it
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			hcount      <= '0;
			vcount      <= '0;
			hpix        <= 1'b0;
			vpix        <= 1'b0;
			hblank      <= 1'b1;
			vblank      <= 1'b1;
			hsync       <= 1'b0;
			vsync       <= 1'b0;
			hsync_start <= 1'b0;
		end
		else
		begin
			hcount      <= h_next;
			vcount      <= v_next;
			hpix        <= (h_next >= HW'(`VID_H_PIX_BEG)) && (h_next < HW'(`VID_H_PIX_END));
			vpix        <= (v_next >= VW'(`VID_V_PIX_BEG)) && (v_next < VW'(`VID_V_PIX_END));
			hblank      <= (h_next >= HW'(`VID_H_BLANK_BEG)); // till wrap
			vblank      <= (v_next >= VW'(`VID_V_BLANK_BEG));
			hsync       <= (h_next >= HW'(`VID_H_SYNC_BEG)) && (h_next < HW'(`VID_H_SYNC_END));
			vsync       <= (v_next >= VW'(`VID_V_SYNC_BEG)) && (v_next < VW'(`VID_V_SYNC_END));
			hsync_start <= (h_next == HW'(`VID_H_SYNC_BEG));
		end
	end

	assign pix_area  = hpix & vpix;
	assign zx_color  = pix_area ? pixels : border; // border outside picture
	assign atm_index = zx_color;

	// palette index, zx or ulaplus decoding
	always_comb
	begin
		pal_index = '0;
		if (up_ena)
		begin
			pal_index.up.tag = 3'b100; // upper half of ram
			if (pix_area)
			begin
				pal_index.up.palsel = up_palsel;
				pal_index.up.paper  = ~up_pixel;
				pal_index.up.color  = up_pixel ? up_ink : up_paper;
			end
			else
				pal_index.up.color = border[2:0]; // group 0 ink entries
		end
		else
			pal_index.zx.color = zx_color;
	end

	// pulse sits on the first sync column and nowhere else
	hsync_start_rise: assert property (
		@(posedge clk) disable iff (!rst_n)
		hsync_start == $rose(hsync)
	);

endmodule

// File: hw/video_palette.sv
/* 512-word palette ram, atm table at 0 and ulaplus table at VID_UP_BASE;
   one registered read per clock with readback and blank kept in step */
`timescale 1ns/1ps
`include "video_consts.svh"

module video_palette
(
	input  logic                  clk,
	input  logic                  rst_n,

	input  video_pkg::pal_index_t pal_index,
	input  logic [3:0]            atm_index,
	input  logic                  hblank,
	input  logic                  vblank,

	// atm write, takes priority
	input  logic                  atm_palwr,
	input  logic [5:0]            atm_paldata,

	// ulaplus write
	input  logic                  up_palwr,
	input  logic [5:0]            up_paladdr,
	input  logic [7:0]            up_paldata,

	output video_pkg::pal_entry_t pal_entry, // valid one clock after index
	output logic [5:0]            palcolor,  // 6-bit readback of pal_entry
	output logic                  blank      // aligned with pal_entry
);
	localparam int AW = $clog2(`VID_PAL_DEPTH);

	video_pkg::pal_entry_t ram [0:`VID_PAL_DEPTH-1];

	logic                  wr_en;
	logic [AW-1:0]         wr_addr;
	video_pkg::pal_entry_t wr_data;

	assign wr_en = atm_palwr | up_palwr;

	always_comb
	begin
		if (atm_palwr)
		begin
			wr_addr = AW'(atm_index); // atm entry under current zx colour
			// rrggbb in, low green and red bits forced 0
			wr_data = {atm_paldata[3:2], 1'b0, atm_paldata[5:4], 1'b0, atm_paldata[1:0]};
		end
		else
		begin
			wr_addr = AW'(`VID_UP_BASE) + AW'(up_paladdr);
			wr_data = up_paldata;
		end
	end

	// write and read on same edge, read sees old word
	always_ff @(posedge clk)
	begin
		if (wr_en)
			ram[wr_addr] <= wr_data;
		pal_entry <= ram[pal_index];
	end

	// top two bits of green and red, then blue
	assign palcolor = {pal_entry.green[2:1], pal_entry.red[2:1], pal_entry.blue};

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			blank <= 1'b1;
		else
			blank <= hblank | vblank; // one clock late like the read
	end

	// any non-zx index must carry the ulaplus tag
	up_tag_ok: assert property (
		@(posedge clk) disable iff (!rst_n)
		(pal_index.up.tag != 3'b000) |-> (pal_index.up.tag == 3'b100)
	);

endmodule

// File: hw/video_dither.sv
/* dac formatter: rotating dither phase, 3-bit to 2-bit reduction of
   red and green, byte packing with black forced during blank */
`timescale 1ns/1ps
`include "video_consts.svh"

module video_dither
(
	input  logic                  clk,
	input  logic                  rst_n,

	input  video_pkg::pal_entry_t pal_entry,
	input  logic                  blank,

	input  logic                  hsync_start, // toggles line phase
	input  logic                  vsync,       // rising edge toggles frame phase

	output logic [7:0]            color
);
	logic       vsync_r;
	logic       vsync_start;
	logic [1:0] phase;      // clock-pair counter
	logic       line_tgl;
	logic       frame_tgl;
	logic       plus1;
	logic [1:0] grn2;
	logic [1:0] red2;

	// 0,2,4 exact; odd values round up on plus1; 6,7 saturate
	function automatic logic [1:0] reduce3
	(
		input logic [`VID_RG_W-1:0] c,
		input logic                 p
	);
		logic [1:0] r;
		case (c)
			3'd0:    r = 2'd0;
			3'd1:    r = p ? 2'd1 : 2'd0;
			3'd2:    r = 2'd1;
			3'd3:    r = p ? 2'd2 : 2'd1;
			3'd4:    r = 2'd2;
			3'd5:    r = p ? 2'd3 : 2'd2;
			default: r = 2'd3;
		endcase
		return r;
	endfunction

	assign vsync_start = vsync & ~vsync_r;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			vsync_r   <= 1'b0;
			phase     <= 2'd0;
			line_tgl  <= 1'b0;
			frame_tgl <= 1'b0;
		end
		else
		begin
			vsync_r <= vsync;
			phase   <= phase + 2'd1; // free running
			if (hsync_start)
				line_tgl <= ~line_tgl;
			if (vsync_start)
				frame_tgl <= ~frame_tgl;
		end
	end

	assign plus1 = phase[1] ^ line_tgl ^ frame_tgl;

	assign grn2 = reduce3(pal_entry.green, plus1);
	assign red2 = reduce3(pal_entry.red, plus1);

	// dac byte gg0rr0bb
	assign color = blank ? 8'd0 : {grn2, 1'b0, red2, 1'b0, pal_entry.blue};

	// reduced field is the truncated one or one above, never below
	rg_near_trunc: assert property (
		@(posedge clk) disable iff (!rst_n)
		(!blank && !$isunknown(pal_entry)) |->
			((grn2 - pal_entry.green[2:1]) <= 2'd1) &&
			((red2 - pal_entry.red[2:1]) <= 2'd1)
	);

endmodule

// File: hw/video_palframe_top.sv
/* pixel-colour back end top: raster producer feeds the palette ram,
   whose registered word goes to the dac formatter; one clock of latency */
`timescale 1ns/1ps

module video_palframe_top
(
	input  logic       clk,
	input  logic       rst_n,

	input  logic [3:0] pixels,
	input  logic [3:0] border,

	input  logic [1:0] up_palsel,
	input  logic [2:0] up_paper,
	input  logic [2:0] up_ink,
	input  logic       up_pixel,
	input  logic       up_ena,

	input  logic       up_palwr,
	input  logic [5:0] up_paladdr,
	input  logic [7:0] up_paldata,

	input  logic       atm_palwr,
	input  logic [5:0] atm_paldata,

	output logic [7:0] color,
	output logic [5:0] palcolor,
	output logic       hsync,
	output logic       vsync
);
	video_pkg::pal_index_t pal_index;
	video_pkg::pal_entry_t pal_entry;
	logic [3:0]            atm_index;
	logic                  hblank;
	logic                  vblank;
	logic                  hsync_start;
	logic                  blank;     // registered, matches pal_entry

	video_raster u_raster
	(
		.clk         (clk),
		.rst_n       (rst_n),
		.pixels      (pixels),
		.border      (border),
		.up_palsel   (up_palsel),
		.up_paper    (up_paper),
		.up_ink      (up_ink),
		.up_pixel    (up_pixel),
		.up_ena      (up_ena),
		.pal_index   (pal_index),
		.atm_index   (atm_index),
		.hblank      (hblank),
		.vblank      (vblank),
		.hsync       (hsync),
		.vsync       (vsync),
		.hsync_start (hsync_start)
	);

	video_palette u_palette
	(
		.clk         (clk),
		.rst_n       (rst_n),
		.pal_index   (pal_index),
		.atm_index   (atm_index),
		.hblank      (hblank),
		.vblank      (vblank),
		.atm_palwr   (atm_palwr),
		.atm_paldata (atm_paldata),
		.up_palwr    (up_palwr),
		.up_paladdr  (up_paladdr),
		.up_paldata  (up_paldata),
		.pal_entry   (pal_entry),
		.palcolor    (palcolor),
		.blank       (blank)
	);

	video_dither u_dither
	(
		.clk         (clk),
		.rst_n       (rst_n),
		.pal_entry   (pal_entry),
		.blank       (blank),
		.hsync_start (hsync_start),
		.vsync       (vsync),    // same level as the top output
		.color       (color)
	);

endmodule

// File: test/tb_video_palframe.sv
/* testbench for the palette back end: loads both palette tables, then runs
   frames from a stimulus table against a shadow palette and dither model */
`timescale 1ns/1ps
`include "video_consts.svh"

module tb_video_palframe;
	localparam int FRAME_LEN = `VID_H_TOTAL * `VID_V_TOTAL;
	localparam int NROWS     = 11;

	typedef struct packed
	{
		logic [1:0] op;      // 0 run frames, 1 atm load, 2 ulaplus load
		logic       up_ena;
		logic [3:0] pixels;
		logic [3:0] border;
		logic [1:0] palsel;
		logic [2:0] paper;
		logic [2:0] ink;
		logic       up_pixel;
		logic       rnd;     // fresh pixel and attributes each clock
		logic [2:0] frames;
	} row_t;

	logic clk, rst_n;
	logic [3:0] pixels, border;
	logic [1:0] up_palsel;
	logic [2:0] up_paper, up_ink;
	logic up_pixel, up_ena, up_palwr, atm_palwr;
	logic [5:0] up_paladdr, atm_paldata;
	logic [7:0] up_paldata, color;
	logic [5:0] palcolor;
	logic hsync, vsync;

	row_t tbl [0:NROWS-1];
	row_t row;
	logic tbl_ready;
	int k;                   // clocks since reset release
	int errors;
	logic line_t, frame_t;   // model dither toggles
	logic hs_prev, vs_prev;
	logic pred_ok, pred_blank; // for the word read last clock
	video_pkg::pal_entry_t pred_entry;
	video_pkg::pal_entry_t shadow [0:`VID_PAL_DEPTH-1];
	bit shadow_ok [0:`VID_PAL_DEPTH-1]; // entry written yet

	video_palframe_top dut (.*);

	always #5 clk = ~clk;

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			errors++;
			$display("mismatch %s: got %h expected %h at clock %0d", name, got, exp, k);
			$display("Test failures found");
			$fatal(1, "stopping at first error");
		end
	endtask

	// 3-bit field to 2 bits, odd values bumped by p, 6 and 7 saturate
	function automatic logic [1:0] shrink_rg(input logic [2:0] c, input logic p);
		if (c >= 3'd6)
			return 2'd3;
		return c[2:1] + {1'b0, c[0] & p};
	endfunction

	// one clock: check this clock's outputs, predict the next, step the model
	task automatic tick;
		video_pkg::pal_index_t idx;
		video_pkg::pal_entry_t wr;
		logic [8:0] addr;
		logic [3:0] zx;
		logic pix, p;
		logic [7:0] exp_color;
		int col, line;
		col  = k % `VID_H_TOTAL;
		line = (k / `VID_H_TOTAL) % `VID_V_TOTAL;
		@(negedge clk);
		check("hsync", hsync, (col >= `VID_H_SYNC_BEG) && (col < `VID_H_SYNC_END));
		check("vsync", vsync, (line >= `VID_V_SYNC_BEG) && (line < `VID_V_SYNC_END));
		p = ((k >> 1) & 1) ^ line_t ^ frame_t; // clock pair, line, frame
		exp_color = 8'd0;
		if (!pred_blank)
			exp_color = {shrink_rg(pred_entry.green, p), 1'b0,
				shrink_rg(pred_entry.red, p), 1'b0, pred_entry.blue};
		if (pred_blank || pred_ok)
			check("color", color, exp_color);
		if (pred_ok)
			check("palcolor", palcolor, {pred_entry.green[2:1], pred_entry.red[2:1],
				pred_entry.blue});
		pix = (col >= `VID_H_PIX_BEG) && (col < `VID_H_PIX_END) &&
			(line >= `VID_V_PIX_BEG) && (line < `VID_V_PIX_END);
		zx  = pix ? pixels : border;
		idx = '0;
		if (!up_ena)
			idx.zx.color = zx;
		else if (!pix)
			idx = {3'b100, 2'b00, 1'b0, border[2:0]}; // border uses group 0 ink
		else
		begin
			idx.up.tag    = 3'b100;
			idx.up.palsel = up_palsel;
			idx.up.paper  = !up_pixel;
			idx.up.color  = up_pixel ? up_ink : up_paper;
		end
		addr       = idx;
		pred_blank = (k == 0) || (col >= `VID_H_BLANK_BEG) || (line >= `VID_V_BLANK_BEG);
		pred_ok    = shadow_ok[addr];
		pred_entry = shadow[addr]; // old word even if written now
		if (atm_palwr)
		begin
			// atm data is rr gg bb
			wr.green = {atm_paldata[3:2], 1'b0};
			wr.red   = {atm_paldata[5:4], 1'b0};
			wr.blue  = atm_paldata[1:0];
			shadow[zx]    = wr;
			shadow_ok[zx] = 1'b1;
		end
		else if (up_palwr)
		begin
			shadow[`VID_UP_BASE + up_paladdr]    = up_paldata;
			shadow_ok[`VID_UP_BASE + up_paladdr] = 1'b1;
		end
		if (hsync && !hs_prev)
			line_t = ~line_t;
		if (vsync && !vs_prev)
			frame_t = ~frame_t;
		hs_prev = hsync;
		vs_prev = vsync;
		k++;
		@(posedge clk);
		#1;
	endtask

	// limit from table length, one frame per load row
	initial
	begin
		int limit;
		wait (tbl_ready);
		limit = 10 + 200;
		for (int i = 0; i < NROWS; i++)
			limit += (tbl[i].op == 2'd0) ? int'(tbl[i].frames) * FRAME_LEN : FRAME_LEN;
		#(limit * 10);
		$display("timeout: run did not finish within %0d clocks", limit);
		$display("Test failures found");
		$fatal(1, "watchdog expired");
	end

	initial
	begin
		clk         = 1'b0;
		rst_n       = 1'b0;
		pixels      = '0;
		border      = '0;
		up_palsel   = '0;
		up_paper    = '0;
		up_ink      = '0;
		up_pixel    = 1'b0;
		up_ena      = 1'b0;
		up_palwr    = 1'b0;
		up_paladdr  = '0;
		up_paldata  = '0;
		atm_palwr   = 1'b0;
		atm_paldata = '0;
		errors      = 0;
		k           = 0;
		void'($urandom(32532));
		//         op     ena   pix   brd   sel   paper ink   upix  rnd   frames
		tbl[0]  = {2'd2, 1'b0, 4'h0, 4'h0, 2'd0, 3'd0, 3'd0, 1'b0, 1'b0, 3'd0};
		tbl[1]  = {2'd1, 1'b0, 4'h0, 4'h0, 2'd0, 3'd0, 3'd0, 1'b0, 1'b0, 3'd0};
		tbl[2]  = {2'd0, 1'b0, 4'h3, 4'h5, 2'd0, 3'd0, 3'd0, 1'b0, 1'b1, 3'd1};
		tbl[3]  = {2'd0, 1'b0, 4'he, 4'h9, 2'd0, 3'd0, 3'd0, 1'b0, 1'b0, 3'd1};
		tbl[4]  = {2'd0, 1'b1, 4'h0, 4'h2, 2'd0, 3'd0, 3'd0, 1'b0, 1'b1, 3'd1};
		tbl[5]  = {2'd0, 1'b1, 4'h0, 4'hb, 2'd1, 3'd0, 3'd0, 1'b0, 1'b1, 3'd1};
		tbl[6]  = {2'd0, 1'b1, 4'h0, 4'h6, 2'd2, 3'd0, 3'd0, 1'b0, 1'b1, 3'd1};
		tbl[7]  = {2'd0, 1'b1, 4'h0, 4'hf, 2'd3, 3'd0, 3'd0, 1'b0, 1'b1, 3'd1};
		tbl[8]  = {2'd0, 1'b1, 4'h0, 4'h1, 2'd2, 3'd3, 3'd5, 1'b1, 1'b0, 3'd2};
		tbl[9]  = {2'd0, 1'b1, 4'h0, 4'h4, 2'd1, 3'd7, 3'd1, 1'b0, 1'b0, 3'd2};
		tbl[10] = {2'd0, 1'b0, 4'h7, 4'h0, 2'd0, 3'd0, 3'd0, 1'b0, 1'b1, 3'd2};
		tbl_ready  = 1'b1;
		line_t     = 1'b0;
		frame_t    = 1'b0;
		hs_prev    = 1'b0;
		vs_prev    = 1'b0;
		pred_ok    = 1'b0;
		pred_blank = 1'b1; // blank reg resets high
		repeat (10) @(posedge clk);
		#1;
		rst_n = 1'b1;
		for (int r = 0; r < NROWS; r++)
		begin
			row       = tbl[r];
			up_ena    = row.up_ena;
			pixels    = row.pixels;
			border    = row.border;
			up_palsel = row.palsel;
			up_paper  = row.paper;
			up_ink    = row.ink;
			up_pixel  = row.up_pixel;
			case (row.op)
				2'd1:
					for (int i = 0; i < 16; i++)
					begin
						pixels      = 4'(i); // zx colour addresses the atm entry
						border      = 4'(i);
						atm_palwr   = 1'b1;
						atm_paldata = $urandom;
						up_palwr    = 1'b1;  // loses to atm
						up_paladdr  = $urandom;
						up_paldata  = $urandom;
						tick();
					end
				2'd2:
					for (int i = 0; i < 64; i++)
					begin
						up_palwr   = 1'b1;
						up_paladdr = 6'(i);
						up_paldata = $urandom;
						tick();
					end
				default:
					for (int n = 0; n < int'(row.frames) * FRAME_LEN; n++)
					begin
						if (row.rnd)
						begin
							pixels   = $urandom;
							up_pixel = $urandom;
							up_ink   = $urandom;
							up_paper = $urandom;
						end
						tick();
					end
			endcase
			atm_palwr = 1'b0;
			up_palwr  = 1'b0;
		end
		if (errors == 0)
		begin
			$display("All tests passed!");
			$finish;
		end
		else
		begin
			$display("Test failures found");
			$fatal(1, "%0d checks failed", errors);
		end
	end

endmodule

// File: build.f
+incdir+hw
hw/video_pkg.sv
hw/video_raster.sv
hw/video_palette.sv
hw/video_dither.sv
hw/video_palframe_top.sv
test/tb_video_palframe.sv
